/* flist.f */
+incdir+hw
hw/pf_pkg.sv
hw/packet_mem.sv
hw/packet_snooper.sv
hw/cpu_adapter.sv
hw/packet_filter_top.sv
test/packet_filter_properties.sv
test/packet_filter_tb.sv

/* hw/cpu_adapter.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module cpu_adapter #(
    parameter int PESS = `PF_PESS
) (
    input  logic                       clk,
    input  logic                       rst,
    // CPU side
    input  logic [`PF_BYTE_ADDR_W-1:0] byte_rd_addr_i,
    input  logic                       cpu_rd_en_i,
    input  pf_pkg::xfer_sz_e           xfer_sz_i,
    input  logic                       cpu_acc_i,
    input  logic                       cpu_rej_i,
    input  logic                       cpu_rdy_ack_i,
    output logic                       cpu_rdy_o,
    output logic [31:0]                cpu_data_o,
    output logic                       cpu_data_vld_o,
    output logic [`PF_LEN_W-1:0]       cpu_byte_len_o,
    // Packet RAM and snooper side
    output logic [`PF_WORD_ADDR_W-1:0] word_rd_addr_o,
    output logic                       rd_en_o,
    output logic                       acc_o,
    output logic                       rej_o,
    output logic                       rdy_ack_o,
    input  logic                       rdy_i,
    input  logic [`PF_WORD_W-1:0]      bigword_i,
    input  logic                       bigword_vld_i,
    input  logic [`PF_LEN_W-1:0]       byte_len_i
);

    localparam int OFF_W   = `PF_BYTE_ADDR_W - `PF_WORD_ADDR_W;
    // Cycles from read enable to RAM data
    localparam int MEM_LAT = 1;
    localparam int EXT_W   = `PF_WORD_W + 32;

    // Offset and size travel alongside the RAM read
    logic [OFF_W-1:0]  off_pipe [MEM_LAT];
    pf_pkg::xfer_sz_e  sz_pipe  [MEM_LAT];
    logic [OFF_W-1:0]  off_d;
    pf_pkg::xfer_sz_e  sz_d;
    logic [EXT_W-1:0]  ext_word;
    logic [31:0]       selected;
    logic [31:0]       resized;

    // Word address at cycle 0
    assign word_rd_addr_o = byte_rd_addr_i[`PF_BYTE_ADDR_W-1:OFF_W];
    assign rd_en_o        = cpu_rd_en_i;

    // One stage per cycle of RAM latency
    always_ff @(posedge clk) begin
        off_pipe[0] <= byte_rd_addr_i[OFF_W-1:0];
        sz_pipe[0]  <= xfer_sz_i;
        for (int i = 1; i < MEM_LAT; i++) begin
            off_pipe[i] <= off_pipe[i-1];
            sz_pipe[i]  <= sz_pipe[i-1];
        end
    end

    assign off_d = off_pipe[MEM_LAT-1];
    assign sz_d  = sz_pipe[MEM_LAT-1];

    // Zero tail fills bytes past the word end
    assign ext_word = {bigword_i, 32'b0} << {off_d, 3'b000};
    assign selected = ext_word[EXT_W-1 -: 32];

    // First byte lands in the top of the result
    always_comb begin
        case (sz_d)
            pf_pkg::XFER_W: resized = selected;
            pf_pkg::XFER_H: resized = {16'b0, selected[31:16]};
            pf_pkg::XFER_B: resized = {24'b0, selected[31:24]};
            default:        resized = '0;
        endcase
    end

    generate
        if (PESS != 0) begin : g_pess
            logic [31:0] data_q;
            logic        vld_q;

            // Extra stage for timing
            always_ff @(posedge clk) begin
                data_q <= resized;
            end

            always_ff @(posedge clk) begin
                if (!rst) begin
                    vld_q <= 1'b0;
                end else begin
                    vld_q <= bigword_vld_i;
                end
            end

            assign cpu_data_o     = data_q;
            assign cpu_data_vld_o = vld_q;
        end else begin : g_direct
            assign cpu_data_o     = resized;
            assign cpu_data_vld_o = bigword_vld_i;
        end
    endgenerate

    // Buffer handshake passes straight through
    assign acc_o          = cpu_acc_i;
    assign rej_o          = cpu_rej_i;
    assign rdy_ack_o      = cpu_rdy_ack_i;
    assign cpu_rdy_o      = rdy_i;
    assign cpu_byte_len_o = byte_len_i;

endmodule

/* hw/packet_filter_top.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module packet_filter_top (
    input  logic                       clk,
    input  logic                       rst,
    // Snooper stream
    input  logic [7:0]                 sn_data_i,
    input  logic                       sn_vld_i,
    input  logic                       sn_last_i,
    output logic                       sn_rdy_o,
    // Filter CPU
    input  logic [`PF_BYTE_ADDR_W-1:0] cpu_byte_addr_i,
    input  logic                       cpu_rd_en_i,
    input  pf_pkg::xfer_sz_e           cpu_xfer_sz_i,
    input  logic                       cpu_rdy_ack_i,
    input  logic                       cpu_acc_i,
    input  logic                       cpu_rej_i,
    output logic                       cpu_rdy_o,
    output logic [`PF_LEN_W-1:0]       cpu_byte_len_o,
    output logic [31:0]                cpu_data_o,
    output logic                       cpu_data_vld_o,
    // Verdict counters
    output logic [`PF_CNT_W-1:0]       acc_cnt_o,
    output logic [`PF_CNT_W-1:0]       rej_cnt_o
);

    // Snooper to RAM
    logic                       wr_en;
    logic [`PF_BYTE_ADDR_W-1:0] wr_addr;
    logic [7:0]                 wr_data;
    // Adapter to RAM
    logic                       rd_en;
    logic [`PF_WORD_ADDR_W-1:0] rd_addr;
    logic [`PF_WORD_W-1:0]      rd_word;
    logic                       rd_vld;
    // Ownership handshake
    logic                       buf_rdy;
    logic [`PF_LEN_W-1:0]       byte_len;
    logic                       rdy_ack;
    logic                       acc;
    logic                       rej;

    packet_snooper u_snooper (
        .clk        (clk),
        .rst        (rst),
        .sn_data_i  (sn_data_i),
        .sn_vld_i   (sn_vld_i),
        .sn_last_i  (sn_last_i),
        .sn_rdy_o   (sn_rdy_o),
        .wr_en_o    (wr_en),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .rdy_ack_i  (rdy_ack),
        .acc_i      (acc),
        .rej_i      (rej),
        .buf_rdy_o  (buf_rdy),
        .byte_len_o (byte_len),
        .acc_cnt_o  (acc_cnt_o),
        .rej_cnt_o  (rej_cnt_o)
    );

    packet_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_word_o (rd_word),
        .rd_vld_o  (rd_vld)
    );

    cpu_adapter #(
        .PESS (`PF_PESS)
    ) u_adapter (
        .clk            (clk),
        .rst            (rst),
        .byte_rd_addr_i (cpu_byte_addr_i),
        .cpu_rd_en_i    (cpu_rd_en_i),
        .xfer_sz_i      (cpu_xfer_sz_i),
        .cpu_acc_i      (cpu_acc_i),
        .cpu_rej_i      (cpu_rej_i),
        .cpu_rdy_ack_i  (cpu_rdy_ack_i),
        .cpu_rdy_o      (cpu_rdy_o),
        .cpu_data_o     (cpu_data_o),
        .cpu_data_vld_o (cpu_data_vld_o),
        .cpu_byte_len_o (cpu_byte_len_o),
        .word_rd_addr_o (rd_addr),
        .rd_en_o        (rd_en),
        .acc_o          (acc),
        .rej_o          (rej),
        .rdy_ack_o      (rdy_ack),
        .rdy_i          (buf_rdy),
        .bigword_i      (rd_word),
        .bigword_vld_i  (rd_vld),
        .byte_len_i     (byte_len)
    );

endmodule

/* hw/packet_mem.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module packet_mem (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en_i,
    input  logic [`PF_BYTE_ADDR_W-1:0] wr_addr_i,
    input  logic [7:0]                 wr_data_i,
    input  logic                       rd_en_i,
    input  logic [`PF_WORD_ADDR_W-1:0] rd_addr_i,
    output logic [`PF_WORD_W-1:0]      rd_word_o,
    output logic                       rd_vld_o
);

    localparam int OFF_W = `PF_BYTE_ADDR_W - `PF_WORD_ADDR_W;
    localparam int DEPTH = 1 << `PF_WORD_ADDR_W;

    logic [`PF_WORD_W-1:0]      mem [DEPTH];
    // Byte address split into word and lane
    logic [`PF_WORD_ADDR_W-1:0] wr_word;
    logic [OFF_W-1:0]           wr_off;

    assign wr_word = wr_addr_i[`PF_BYTE_ADDR_W-1:OFF_W];
    assign wr_off  = wr_addr_i[OFF_W-1:0];

    // Byte k sits in the big-endian lane k mod 8
    // Lane 0 is the top byte of the word
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_word][(`PF_WORD_W - 1) - 8 * int'(wr_off) -: 8] <= wr_data_i;
        end
    end

    // Registered read port with one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_word_o <= mem[rd_addr_i];
        end
    end

    // Valid tracks the read enable
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_vld_o <= 1'b0;
        end else begin
            rd_vld_o <= rd_en_i;
        end
    end

endmodule

/* hw/packet_snooper.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module packet_snooper (
    input  logic                       clk,
    input  logic                       rst,
    // Incoming byte stream
    input  logic [7:0]                 sn_data_i,
    input  logic                       sn_vld_i,
    input  logic                       sn_last_i,
    output logic                       sn_rdy_o,
    // Packet RAM write port
    output logic                       wr_en_o,
    output logic [`PF_BYTE_ADDR_W-1:0] wr_addr_o,
    output logic [7:0]                 wr_data_o,
    // Buffer handshake with the CPU side
    input  logic                       rdy_ack_i,
    input  logic                       acc_i,
    input  logic                       rej_i,
    output logic                       buf_rdy_o,
    output logic [`PF_LEN_W-1:0]       byte_len_o,
    // Verdict statistics
    output logic [`PF_CNT_W-1:0]       acc_cnt_o,
    output logic [`PF_CNT_W-1:0]       rej_cnt_o
);

    // Largest length that can be stored
    localparam logic [`PF_LEN_W-1:0] MAX_LEN = `PF_LEN_W'(1 << `PF_BYTE_ADDR_W);

    pf_pkg::buf_state_e         state_q;
    logic [`PF_BYTE_ADDR_W-1:0] wr_ptr_q;
    logic [`PF_LEN_W-1:0]       cnt_q;
    logic [`PF_LEN_W-1:0]       cnt_nxt;
    logic [`PF_LEN_W-1:0]       len_q;
    logic                       take;
    logic                       verdict;

    assign sn_rdy_o  = (state_q == pf_pkg::BUF_FILL);
    assign buf_rdy_o = (state_q == pf_pkg::BUF_READY);

    // Byte accepted only while filling
    assign take = sn_vld_i && sn_rdy_o;

    // Verdicts only count once the CPU owns the buffer
    assign verdict = (state_q == pf_pkg::BUF_CLAIMED) && (acc_i || rej_i);

    // Length saturates at the buffer size
    assign cnt_nxt = (cnt_q == MAX_LEN) ? MAX_LEN : cnt_q + 1'b1;

    // Accepted byte goes straight to the RAM
    assign wr_en_o    = take;
    assign wr_addr_o  = wr_ptr_q;
    assign wr_data_o  = sn_data_i;
    assign byte_len_o = len_q;

    // Buffer ownership FSM
    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q  <= pf_pkg::BUF_FILL;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
            len_q    <= '0;
        end else begin
            case (state_q)
                pf_pkg::BUF_FILL: begin
                    if (take) begin
                        // Pointer wraps on oversized packets
                        wr_ptr_q <= wr_ptr_q + 1'b1;
                        cnt_q    <= cnt_nxt;
                        if (sn_last_i) begin
                            len_q   <= cnt_nxt;
                            state_q <= pf_pkg::BUF_READY;
                        end
                    end
                end
                pf_pkg::BUF_READY: begin
                    if (rdy_ack_i) begin
                        state_q <= pf_pkg::BUF_CLAIMED;
                    end
                end
                pf_pkg::BUF_CLAIMED: begin
                    // Old contents are stale from here on
                    if (verdict) begin
                        state_q  <= pf_pkg::BUF_FILL;
                        wr_ptr_q <= '0;
                        cnt_q    <= '0;
                    end
                end
                default: begin
                    state_q <= pf_pkg::BUF_FILL;
                end
            endcase
        end
    end

    // Accept wins if both strobes come together
    always_ff @(posedge clk) begin
        if (!rst) begin
            acc_cnt_o <= '0;
            rej_cnt_o <= '0;
        end else if (verdict) begin
            if (acc_i) begin
                acc_cnt_o <= acc_cnt_o + 1'b1;
            end else begin
                rej_cnt_o <= rej_cnt_o + 1'b1;
            end
        end
    end

endmodule

/* hw/pf_cfg.svh */
`ifndef PF_CFG_SVH
`define PF_CFG_SVH

// Byte address into the 256 byte buffer
`define PF_BYTE_ADDR_W 8
// Address of one wide RAM word
`define PF_WORD_ADDR_W 5
// Eight bytes per RAM word
`define PF_WORD_W 64

// Latched packet length
`define PF_LEN_W 16
// Accept and reject counters
`define PF_CNT_W 16
// Extra output register in the CPU adapter
`define PF_PESS 0

`endif

/* hw/pf_pkg.sv */
package pf_pkg;

    // Transfer size in BPF size field order
    typedef enum logic [1:0] {
        XFER_W = 2'd0,
        // Halfword is two bytes
        XFER_H = 2'd1,
        XFER_B = 2'd2
    } xfer_sz_e;

    // Ownership of the single packet buffer
    typedef enum logic [1:0] {
        // Snooper owns the RAM and takes bytes
        BUF_FILL    = 2'd0,
        // Packet complete and offered to the CPU
        BUF_READY   = 2'd1,
        // CPU has acknowledged and reads freely
        BUF_CLAIMED = 2'd2
    } buf_state_e;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the packet filter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module packet_filter_tb \
    --Mdir obj_dir -o packet_filter_sim \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/packet_filter_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

/* test/packet_filter_properties.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module packet_filter_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 sn_vld_i,
    input logic                 sn_last_i,
    input logic                 sn_rdy_o,
    input logic                 cpu_rd_en_i,
    input logic                 cpu_acc_i,
    input logic                 cpu_rej_i,
    input logic                 cpu_rdy_o,
    input logic                 cpu_data_vld_o,
    input logic [`PF_LEN_W-1:0] cpu_byte_len_o,
    input logic [`PF_CNT_W-1:0] acc_cnt_o,
    input logic [`PF_CNT_W-1:0] rej_cnt_o
);

    // Idle outputs on the first edge after reset release
    assert property (@(posedge clk) $rose(rst) |-> sn_rdy_o && !cpu_rdy_o && !cpu_data_vld_o
                     && acc_cnt_o == '0 && rej_cnt_o == '0 && cpu_byte_len_o == '0)
        else $error("outputs not idle after reset release");

    // One cycle RAM read latency
    assert property (@(posedge clk) disable iff (!rst) cpu_rd_en_i |=> cpu_data_vld_o)
        else $error("read data valid missing one cycle after read enable");
    assert property (@(posedge clk) disable iff (!rst) !cpu_rd_en_i |=> !cpu_data_vld_o)
        else $error("read data valid without a read one cycle earlier");

    // Last byte hands the buffer over on the next cycle
    assert property (@(posedge clk) disable iff (!rst)
                     sn_vld_i && sn_rdy_o && sn_last_i |=> cpu_rdy_o)
        else $error("buffer not ready one cycle after the last byte");

    // Verdict before the claim is ignored
    assert property (@(posedge clk) disable iff (!rst)
                     cpu_rdy_o && (cpu_acc_i || cpu_rej_i)
                     |=> $stable(acc_cnt_o) && $stable(rej_cnt_o))
        else $error("verdict counted while the buffer was only ready");

    // Counters only step by one
    assert property (@(posedge clk) disable iff (!rst)
                     !$stable(acc_cnt_o) |-> acc_cnt_o == $past(acc_cnt_o) + `PF_CNT_W'(1))
        else $error("accept counter jumped");
    assert property (@(posedge clk) disable iff (!rst)
                     !$stable(rej_cnt_o) |-> rej_cnt_o == $past(rej_cnt_o) + `PF_CNT_W'(1))
        else $error("reject counter jumped");

endmodule

bind packet_filter_top packet_filter_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .sn_vld_i       (sn_vld_i),
    .sn_last_i      (sn_last_i),
    .sn_rdy_o       (sn_rdy_o),
    .cpu_rd_en_i    (cpu_rd_en_i),
    .cpu_acc_i      (cpu_acc_i),
    .cpu_rej_i      (cpu_rej_i),
    .cpu_rdy_o      (cpu_rdy_o),
    .cpu_data_vld_o (cpu_data_vld_o),
    .cpu_byte_len_o (cpu_byte_len_o),
    .acc_cnt_o      (acc_cnt_o),
    .rej_cnt_o      (rej_cnt_o)
);

/* test/packet_filter_tb.sv */
`timescale 1ns/1ps
`include "pf_cfg.svh"

module packet_filter_tb;

    localparam int WAIT_LIMIT = 100;
    localparam int NUM_READS  = 64;

    logic                       clk;
    logic                       rst;
    logic [7:0]                 sn_data;
    logic                       sn_vld;
    logic                       sn_last;
    logic                       sn_rdy_o;
    logic [`PF_BYTE_ADDR_W-1:0] cpu_byte_addr;
    logic                       cpu_rd_en;
    pf_pkg::xfer_sz_e           cpu_xfer_sz;
    logic                       cpu_rdy_ack;
    logic                       cpu_acc;
    logic                       cpu_rej;
    logic                       cpu_rdy_o;
    logic [`PF_LEN_W-1:0]       cpu_byte_len_o;
    logic [31:0]                cpu_data_o;
    logic                       cpu_data_vld_o;
    logic [`PF_CNT_W-1:0]       acc_cnt_o;
    logic [`PF_CNT_W-1:0]       rej_cnt_o;

    int          seed = 23164;
    // Reference copy of the current packet
    logic [7:0]  model [256];
    // Outstanding reads in issue order
    logic [31:0] exp_q [$];
    string       name_q [$];

    packet_filter_top dut (
        .clk             (clk),
        .rst             (rst),
        .sn_data_i       (sn_data),
        .sn_vld_i        (sn_vld),
        .sn_last_i       (sn_last),
        .sn_rdy_o        (sn_rdy_o),
        .cpu_byte_addr_i (cpu_byte_addr),
        .cpu_rd_en_i     (cpu_rd_en),
        .cpu_xfer_sz_i   (cpu_xfer_sz),
        .cpu_rdy_ack_i   (cpu_rdy_ack),
        .cpu_acc_i       (cpu_acc),
        .cpu_rej_i       (cpu_rej),
        .cpu_rdy_o       (cpu_rdy_o),
        .cpu_byte_len_o  (cpu_byte_len_o),
        .cpu_data_o      (cpu_data_o),
        .cpu_data_vld_o  (cpu_data_vld_o),
        .acc_cnt_o       (acc_cnt_o),
        .rej_cnt_o       (rej_cnt_o)
    );

    always #10 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
            else fail_now($sformatf("[FAIL] %s: expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    // Big-endian bytes from the model, zero past the word end
    function automatic logic [31:0] expected_read(input int addr, input pf_pkg::xfer_sz_e sz);
        int          nbytes;
        logic [31:0] val;
        logic [7:0]  b;
        nbytes = (sz == pf_pkg::XFER_W) ? 4 : (sz == pf_pkg::XFER_H) ? 2 : 1;
        val = '0;
        for (int k = 0; k < nbytes; k++) begin
            if ((addr % 8) + k < 8) b = model[8'(addr + k)];
            else b = 8'h00;
            val = {val[23:0], b};
        end
        return val;
    endfunction

    task automatic wait_cpu_rdy(input logic level);
        int cycles;
        cycles = 0;
        while (cpu_rdy_o !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) fail_now("timeout waiting for the CPU ready level");
        end
    endtask

    task automatic wait_sn_rdy();
        int cycles;
        cycles = 0;
        while (sn_rdy_o !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) fail_now("timeout waiting for the snooper to take bytes");
        end
    endtask

    task automatic wait_reads_done();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) fail_now("timeout waiting for read data");
        end
    endtask

    task automatic fill_model(input int len);
        for (int i = 0; i < len; i++) model[8'(i)] = 8'($random(seed));
    endtask

    task automatic send_packet(input int len);
        wait_sn_rdy();
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            sn_vld  <= 1'b1;
            sn_data <= model[8'(i)];
            sn_last <= (i == len - 1);
        end
        @(posedge clk);
        sn_vld  <= 1'b0;
        sn_last <= 1'b0;
    endtask

    // Bytes offered while the CPU owns the buffer must be dropped
    task automatic offer_while_busy(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            sn_vld  <= 1'b1;
            sn_data <= 8'($random(seed));
            sn_last <= 1'b1;
            @(negedge clk);
            assert (!sn_rdy_o) else fail_now("snooper took bytes while the buffer was busy");
        end
        @(posedge clk);
        sn_vld  <= 1'b0;
        sn_last <= 1'b0;
    endtask

    task automatic drive_strobes(input logic ack, input logic acc, input logic rej);
        @(posedge clk);
        cpu_rdy_ack <= ack;
        cpu_acc     <= acc;
        cpu_rej     <= rej;
        @(posedge clk);
        cpu_rdy_ack <= 1'b0;
        cpu_acc     <= 1'b0;
        cpu_rej     <= 1'b0;
    endtask

    task automatic issue_read(input int addr, input pf_pkg::xfer_sz_e sz);
        @(posedge clk);
        cpu_rd_en     <= 1'b1;
        cpu_byte_addr <= `PF_BYTE_ADDR_W'(addr);
        cpu_xfer_sz   <= sz;
        exp_q.push_back(expected_read(addr, sz));
        name_q.push_back($sformatf("read addr %0d %s", addr, sz.name()));
    endtask

    // Back-to-back reads, all bytes inside the packet
    task automatic run_reads(input int len, input int n);
        int pick;
        int addr;
        // Word and halfword that run past a word end
        issue_read(13, pf_pkg::XFER_W);
        issue_read(15, pf_pkg::XFER_H);
        for (int i = 0; i < n; i++) begin
            addr = int'($unsigned($random(seed)) % (len - 3));
            pick = int'($unsigned($random(seed)) % 3);
            issue_read(addr, pf_pkg::xfer_sz_e'(pick[1:0]));
        end
        @(posedge clk);
        cpu_rd_en <= 1'b0;
        wait_reads_done();
    endtask

    // Compare returned data where it is stable
    always @(negedge clk) begin
        if (rst && cpu_data_vld_o) begin
            if (exp_q.size() == 0) fail_now("read data valid without an outstanding read");
            else check_value(name_q.pop_front(), exp_q.pop_front(), cpu_data_o);
        end
    end

    initial begin
        int len1;
        int len2;
        clk           = 1'b0;
        rst           = 1'b0;
        sn_data       = '0;
        sn_vld        = 1'b0;
        sn_last       = 1'b0;
        cpu_byte_addr = '0;
        cpu_rd_en     = 1'b0;
        cpu_xfer_sz   = pf_pkg::XFER_B;
        cpu_rdy_ack   = 1'b0;
        cpu_acc       = 1'b0;
        cpu_rej       = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        assert (sn_rdy_o && !cpu_rdy_o && !cpu_data_vld_o) else fail_now("wrong state after reset");

        // First packet, early verdict then accept
        len1 = 20 + int'($unsigned($random(seed)) % 181);
        fill_model(len1);
        send_packet(len1);
        wait_cpu_rdy(1'b1);
        check_value("length of packet 1", 32'(len1), 32'(cpu_byte_len_o));
        offer_while_busy(3);
        check_value("length held while ready", 32'(len1), 32'(cpu_byte_len_o));
        drive_strobes(1'b0, 1'b1, 1'b0);
        @(negedge clk);
        check_value("accept count after early verdict", 32'd0, 32'(acc_cnt_o));
        drive_strobes(1'b1, 1'b0, 1'b0);
        wait_cpu_rdy(1'b0);
        offer_while_busy(3);
        run_reads(len1, NUM_READS);
        drive_strobes(1'b0, 1'b1, 1'b0);
        wait_sn_rdy();
        check_value("accept count after packet 1", 32'd1, 32'(acc_cnt_o));
        check_value("reject count after packet 1", 32'd0, 32'(rej_cnt_o));

        // Second packet overwrites from address 0, then reject
        len2 = 20 + int'($unsigned($random(seed)) % 181);
        fill_model(len2);
        send_packet(len2);
        wait_cpu_rdy(1'b1);
        check_value("length of packet 2", 32'(len2), 32'(cpu_byte_len_o));
        drive_strobes(1'b1, 1'b0, 1'b0);
        wait_cpu_rdy(1'b0);
        run_reads(len2, NUM_READS);
        drive_strobes(1'b0, 1'b0, 1'b1);
        wait_sn_rdy();
        check_value("reject count after packet 2", 32'd1, 32'(rej_cnt_o));
        check_value("accept count after packet 2", 32'd1, 32'(acc_cnt_o));

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
